//--- common/updi_cfg.svh
// UPDI opcodes, CS register addresses, NVMPROG key bytes, reset signature and sequencer limits
`ifndef UPDI_CFG_SVH
`define UPDI_CFG_SVH

// every frame begins with the sync character
`define UPDI_SYNC            8'h55

// opcodes, the CS address is added into LDCS and STCS
`define UPDI_OP_LDCS         8'h80
`define UPDI_OP_STCS         8'hC0
`define UPDI_OP_KEY          8'hE0
`define UPDI_OP_ST_PTR       8'h69
`define UPDI_OP_REPEAT       8'hA0
`define UPDI_OP_LD_INC       8'h24

// control and status space
`define UPDI_CS_STATUSA      4'h0
`define UPDI_CS_KEY_STATUS   4'h7
`define UPDI_CS_RESET_REQ    4'h8
`define UPDI_CS_SYS_STATUS   4'hB

// start of the signature row
`define UPDI_SIG_BASE        16'h1100

`define UPDI_RESET_SIG       8'h59

// NVMPROG key in send order, least significant byte first
`define UPDI_KEY_NVMPROG_B0  8'h20
`define UPDI_KEY_NVMPROG_B1  8'h67
`define UPDI_KEY_NVMPROG_B2  8'h6F
`define UPDI_KEY_NVMPROG_B3  8'h72
`define UPDI_KEY_NVMPROG_B4  8'h50
`define UPDI_KEY_NVMPROG_B5  8'h4D
`define UPDI_KEY_NVMPROG_B6  8'h56
`define UPDI_KEY_NVMPROG_B7  8'h4E

`define UPDI_DELAY_CLKS      100
`define UPDI_MAX_POLLS       8
`define UPDI_ID_BYTES        3

`endif

//--- common/updi_pkg.sv
// byte, command, error, device ID and controller state types for the UPDI sequencer
`default_nettype none
`include "updi_cfg.svh"

package updi_pkg;

	typedef logic [7:0] updi_byte_t;

	// frame kinds understood by the frame transmitter
	typedef enum logic [2:0] {
		CMD_LDCS,
		CMD_STCS,
		CMD_KEY,
		CMD_ST_PTR,
		CMD_REPEAT,
		CMD_LD_INC
	} updi_cmd_e;

	typedef enum logic [1:0] {
		ERR_NONE,
		ERR_NO_STATUS,
		ERR_KEY_LOCKED,
		ERR_POLL_TIMEOUT
	} updi_err_e;

	// index 0 holds the first signature byte received
	typedef updi_byte_t [`UPDI_ID_BYTES-1:0] updi_dev_id_t;

	// command issue states hand over to ST_TX_WAIT and ST_RX_WAIT
	typedef enum logic [4:0] {
		ST_IDLE,
		ST_BREAK,
		ST_BREAK_WAIT,
		ST_STATUS_RD,
		ST_STATUS_CHK,
		ST_KEY,
		ST_KEY_RD,
		ST_KEY_CHK,
		ST_RST_SET,
		ST_RST_DELAY,
		ST_RST_CLR,
		ST_SYS_RD,
		ST_SYS_CHK,
		ST_SYS_DELAY,
		ST_PTR,
		ST_REPEAT,
		ST_LD,
		ST_TX_WAIT,
		ST_RX_WAIT,
		ST_DONE,
		ST_ERROR
	} updi_state_e;

endpackage

`default_nettype wire

//--- rtl/updi_frame_tx.sv
// UPDI frame transmitter that serializes one command into the UART TX FIFO
`timescale 1ns/1ps
`default_nettype none
`include "updi_cfg.svh"

module updi_frame_tx (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 cmd_valid,
	input  updi_pkg::updi_cmd_e  cmd,
	input  logic [3:0]           cs_addr,
	input  updi_pkg::updi_byte_t cmd_data,
	output logic                 cmd_done,
	output updi_pkg::updi_byte_t uart_tx_data,
	output logic                 uart_tx_wr_en,
	input  logic                 uart_tx_full
);

	localparam logic [15:0] PTR_ADDR = `UPDI_SIG_BASE;
	localparam updi_pkg::updi_byte_t KEY_BYTES [8] = '{
		`UPDI_KEY_NVMPROG_B0, `UPDI_KEY_NVMPROG_B1, `UPDI_KEY_NVMPROG_B2, `UPDI_KEY_NVMPROG_B3,
		`UPDI_KEY_NVMPROG_B4, `UPDI_KEY_NVMPROG_B5, `UPDI_KEY_NVMPROG_B6, `UPDI_KEY_NVMPROG_B7
	};

	updi_pkg::updi_cmd_e  cmd_q;
	logic [3:0]           cs_q;
	updi_pkg::updi_byte_t data_q;
	logic                 active;
	logic [3:0]           idx;
	logic [3:0]           last_idx;

	assign uart_tx_wr_en = active && !uart_tx_full;

	// frame length minus one, sync and opcode included
	always_comb begin
		case (cmd_q)
			updi_pkg::CMD_STCS, updi_pkg::CMD_REPEAT: last_idx = 4'd2;
			updi_pkg::CMD_KEY:    last_idx = 4'd9;
			updi_pkg::CMD_ST_PTR: last_idx = 4'd3;
			default:              last_idx = 4'd1;
		endcase
	end

	always_comb begin
		uart_tx_data = `UPDI_SYNC;
		if (idx == 4'd1) begin
			case (cmd_q)
				updi_pkg::CMD_LDCS:   uart_tx_data = `UPDI_OP_LDCS + {4'h0, cs_q};
				updi_pkg::CMD_STCS:   uart_tx_data = `UPDI_OP_STCS + {4'h0, cs_q};
				updi_pkg::CMD_KEY:    uart_tx_data = `UPDI_OP_KEY;
				updi_pkg::CMD_ST_PTR: uart_tx_data = `UPDI_OP_ST_PTR;
				updi_pkg::CMD_REPEAT: uart_tx_data = `UPDI_OP_REPEAT;
				default:              uart_tx_data = `UPDI_OP_LD_INC;
			endcase
		end else if (idx != 4'd0) begin
			case (cmd_q)
				updi_pkg::CMD_KEY: begin
					uart_tx_data = KEY_BYTES[3'(idx - 4'd2)];
				end
				updi_pkg::CMD_ST_PTR: begin
					// address goes out low byte first
					uart_tx_data = (idx == 4'd2) ? PTR_ADDR[7:0] : PTR_ADDR[15:8];
				end
				default: begin
					uart_tx_data = data_q;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			cmd_q  <= cmd;
			cs_q   <= cs_addr;
			data_q <= cmd_data;
		end
	end

	// index only advances on an accepted write, so a full FIFO holds the byte
	always_ff @(posedge clk) begin
		if (rst) begin
			active   <= 1'b0;
			idx      <= 4'd0;
			cmd_done <= 1'b0;
		end else begin
			cmd_done <= 1'b0;
			if (cmd_valid) begin
				active <= 1'b1;
				idx    <= 4'd0;
			end else if (uart_tx_wr_en) begin
				if (idx == last_idx) begin
					active   <= 1'b0;
					cmd_done <= 1'b1;
				end else begin
					idx <= idx + 4'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/updi_rx_collect.sv
// response collector that pops a requested number of bytes from the UART RX FIFO
`timescale 1ns/1ps
`default_nettype none

module updi_rx_collect (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   rx_start,
	input  logic [1:0]             rx_count,
	output logic                   rx_done,
	output updi_pkg::updi_dev_id_t rx_bytes,
	input  updi_pkg::updi_byte_t   uart_rx_data,
	input  logic                   uart_rx_empty,
	output logic                   uart_rx_rd_en
);

	logic [1:0] remaining;
	logic [1:0] idx;

	// one pop per cycle while bytes are still owed
	assign uart_rx_rd_en = remaining != 2'd0 && !uart_rx_empty;

	always_ff @(posedge clk) begin
		if (rst) begin
			remaining <= 2'd0;
			idx       <= 2'd0;
			rx_done   <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			if (rx_start) begin
				remaining <= rx_count;
				idx       <= 2'd0;
			end else if (uart_rx_rd_en) begin
				remaining <= remaining - 2'd1;
				idx       <= idx + 2'd1;
				if (remaining == 2'd1) begin
					rx_done <= 1'b1;
				end
			end
		end
	end

	// head byte is stored at its arrival index
	always_ff @(posedge clk) begin
		if (uart_rx_rd_en) begin
			rx_bytes[idx] <= uart_rx_data;
		end
	end

endmodule

`default_nettype wire

//--- updi_prog_ctrl/updi_prog_ctrl.sv
// UPDI sequencing FSM with delay counter, poll counter and status checks
`timescale 1ns/1ps
`default_nettype none
`include "updi_cfg.svh"

module updi_prog_ctrl (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	output logic                   busy,
	output logic                   done,
	output logic                   error,
	output updi_pkg::updi_err_e    error_code,
	output logic                   break_start,
	input  logic                   break_done,
	output logic                   cmd_valid,
	output updi_pkg::updi_cmd_e    cmd,
	output logic [3:0]             cs_addr,
	output updi_pkg::updi_byte_t   cmd_data,
	input  logic                   cmd_done,
	output logic                   rx_start,
	output logic [1:0]             rx_count,
	input  updi_pkg::updi_dev_id_t rx_bytes,
	input  logic                   rx_done
);

	localparam int DELAY_W = $clog2(`UPDI_DELAY_CLKS + 1);
	localparam int POLL_W  = $clog2(`UPDI_MAX_POLLS + 1);

	updi_pkg::updi_state_e state;
	updi_pkg::updi_state_e ret_state;
	updi_pkg::updi_state_e next_ret;
	logic [1:0]            rd_count;
	logic [1:0]            next_rd;
	logic [DELAY_W-1:0]    delay_cnt;
	logic [POLL_W-1:0]     poll_cnt;
	logic                  in_delay;
	logic                  delay_done;
	updi_pkg::updi_byte_t  status;

	// single-byte reads land in byte 0
	assign status = rx_bytes[0];

	assign busy        = state != updi_pkg::ST_IDLE;
	assign done        = state == updi_pkg::ST_DONE;
	assign error       = state == updi_pkg::ST_ERROR;
	assign break_start = state == updi_pkg::ST_BREAK;

	// response read starts once the request frame is out
	assign rx_start = state == updi_pkg::ST_TX_WAIT && cmd_done && rd_count != 2'd0;
	assign rx_count = rd_count;

	assign in_delay   = state == updi_pkg::ST_RST_DELAY || state == updi_pkg::ST_SYS_DELAY;
	assign delay_done = delay_cnt == DELAY_W'(`UPDI_DELAY_CLKS - 1);

	// delay states last exactly UPDI_DELAY_CLKS cycles
	always_ff @(posedge clk) begin
		if (rst || !in_delay) begin
			delay_cnt <= '0;
		end else begin
			delay_cnt <= delay_cnt + 1'b1;
		end
	end

	// command fields per issue state, plus where to go once it completes
	always_comb begin
		cmd_valid = 1'b1;
		cmd       = updi_pkg::CMD_LDCS;
		cs_addr   = 4'h0;
		cmd_data  = 8'h00;
		next_ret  = updi_pkg::ST_IDLE;
		next_rd   = 2'd0;
		case (state)
			updi_pkg::ST_STATUS_RD: begin
				cs_addr  = `UPDI_CS_STATUSA;
				next_ret = updi_pkg::ST_STATUS_CHK;
				next_rd  = 2'd1;
			end
			updi_pkg::ST_KEY: begin
				cmd      = updi_pkg::CMD_KEY;
				next_ret = updi_pkg::ST_KEY_RD;
			end
			updi_pkg::ST_KEY_RD: begin
				cs_addr  = `UPDI_CS_KEY_STATUS;
				next_ret = updi_pkg::ST_KEY_CHK;
				next_rd  = 2'd1;
			end
			updi_pkg::ST_RST_SET: begin
				cmd      = updi_pkg::CMD_STCS;
				cs_addr  = `UPDI_CS_RESET_REQ;
				cmd_data = `UPDI_RESET_SIG;
				next_ret = updi_pkg::ST_RST_DELAY;
			end
			updi_pkg::ST_RST_CLR: begin
				cmd      = updi_pkg::CMD_STCS;
				cs_addr  = `UPDI_CS_RESET_REQ;
				next_ret = updi_pkg::ST_SYS_RD;
			end
			updi_pkg::ST_SYS_RD: begin
				cs_addr  = `UPDI_CS_SYS_STATUS;
				next_ret = updi_pkg::ST_SYS_CHK;
				next_rd  = 2'd1;
			end
			updi_pkg::ST_PTR: begin
				// transmitter supplies the signature base address
				cmd      = updi_pkg::CMD_ST_PTR;
				next_ret = updi_pkg::ST_REPEAT;
			end
			updi_pkg::ST_REPEAT: begin
				cmd      = updi_pkg::CMD_REPEAT;
				cmd_data = 8'(`UPDI_ID_BYTES - 1);
				next_ret = updi_pkg::ST_LD;
			end
			updi_pkg::ST_LD: begin
				cmd      = updi_pkg::CMD_LD_INC;
				next_ret = updi_pkg::ST_DONE;
				next_rd  = 2'(`UPDI_ID_BYTES);
			end
			default: begin
				cmd_valid = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= updi_pkg::ST_IDLE;
			ret_state  <= updi_pkg::ST_IDLE;
			rd_count   <= 2'd0;
			poll_cnt   <= '0;
			error_code <= updi_pkg::ERR_NONE;
		end else begin
			case (state)
				updi_pkg::ST_IDLE: begin
					if (start) begin
						state      <= updi_pkg::ST_BREAK;
						poll_cnt   <= '0;
						error_code <= updi_pkg::ERR_NONE;
					end
				end
				updi_pkg::ST_BREAK: begin
					state <= updi_pkg::ST_BREAK_WAIT;
				end
				updi_pkg::ST_BREAK_WAIT: begin
					if (break_done) begin
						state <= updi_pkg::ST_STATUS_RD;
					end
				end
				updi_pkg::ST_TX_WAIT: begin
					if (cmd_done) begin
						state <= (rd_count != 2'd0) ? updi_pkg::ST_RX_WAIT : ret_state;
					end
				end
				updi_pkg::ST_RX_WAIT: begin
					if (rx_done) begin
						state <= ret_state;
					end
				end
				updi_pkg::ST_STATUS_CHK: begin
					// an unsynchronized link reads back zero
					if (status != 8'h00) begin
						state <= updi_pkg::ST_KEY;
					end else begin
						error_code <= updi_pkg::ERR_NO_STATUS;
						state      <= updi_pkg::ST_ERROR;
					end
				end
				updi_pkg::ST_KEY_CHK: begin
					// bit 4 is NVMPROG key accepted
					if (status[4]) begin
						state <= updi_pkg::ST_RST_SET;
					end else begin
						error_code <= updi_pkg::ERR_KEY_LOCKED;
						state      <= updi_pkg::ST_ERROR;
					end
				end
				updi_pkg::ST_RST_DELAY: begin
					if (delay_done) begin
						state <= updi_pkg::ST_RST_CLR;
					end
				end
				updi_pkg::ST_SYS_CHK: begin
					// bit 3 set once the target is in NVM programming mode
					if (status[3]) begin
						state <= updi_pkg::ST_PTR;
					end else if (poll_cnt == POLL_W'(`UPDI_MAX_POLLS - 1)) begin
						error_code <= updi_pkg::ERR_POLL_TIMEOUT;
						state      <= updi_pkg::ST_ERROR;
					end else begin
						poll_cnt <= poll_cnt + 1'b1;
						state    <= updi_pkg::ST_SYS_DELAY;
					end
				end
				updi_pkg::ST_SYS_DELAY: begin
					if (delay_done) begin
						state <= updi_pkg::ST_SYS_RD;
					end
				end
				updi_pkg::ST_DONE, updi_pkg::ST_ERROR: begin
					state <= updi_pkg::ST_IDLE;
				end
				default: begin
					// command issue states, anything else falls back to idle
					if (cmd_valid) begin
						state     <= updi_pkg::ST_TX_WAIT;
						ret_state <= next_ret;
						rd_count  <= next_rd;
					end else begin
						state <= updi_pkg::ST_IDLE;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/updi_programmer.sv
// top level of the UPDI programmer sequencer: controller, frame transmitter, response collector
`timescale 1ns/1ps
`default_nettype none

module updi_programmer (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	output logic                  busy,
	output logic                  done,
	output logic                  error,
	output updi_pkg::updi_err_e   error_code,
	output updi_pkg::updi_dev_id_t device_id,
	output updi_pkg::updi_byte_t  uart_tx_data,
	output logic                  uart_tx_wr_en,
	input  logic                  uart_tx_full,
	input  updi_pkg::updi_byte_t  uart_rx_data,
	input  logic                  uart_rx_empty,
	output logic                  uart_rx_rd_en,
	output logic                  break_start,
	input  logic                  break_done
);

	// controller to frame transmitter
	logic                 cmd_valid;
	logic                 cmd_done;
	updi_pkg::updi_cmd_e  cmd;
	logic [3:0]           cs_addr;
	updi_pkg::updi_byte_t cmd_data;

	// controller to collector
	logic                   rx_start;
	logic                   rx_done;
	logic [1:0]             rx_count;
	updi_pkg::updi_dev_id_t rx_bytes;

	updi_prog_ctrl updi_prog_ctrl_i (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.busy        (busy),
		.done        (done),
		.error       (error),
		.error_code  (error_code),
		.break_start (break_start),
		.break_done  (break_done),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.cs_addr     (cs_addr),
		.cmd_data    (cmd_data),
		.cmd_done    (cmd_done),
		.rx_start    (rx_start),
		.rx_count    (rx_count),
		.rx_bytes    (rx_bytes),
		.rx_done     (rx_done)
	);

	updi_frame_tx updi_frame_tx_i (
		.clk           (clk),
		.rst           (rst),
		.cmd_valid     (cmd_valid),
		.cmd           (cmd),
		.cs_addr       (cs_addr),
		.cmd_data      (cmd_data),
		.cmd_done      (cmd_done),
		.uart_tx_data  (uart_tx_data),
		.uart_tx_wr_en (uart_tx_wr_en),
		.uart_tx_full  (uart_tx_full)
	);

	updi_rx_collect updi_rx_collect_i (
		.clk           (clk),
		.rst           (rst),
		.rx_start      (rx_start),
		.rx_count      (rx_count),
		.rx_done       (rx_done),
		.rx_bytes      (rx_bytes),
		.uart_rx_data  (uart_rx_data),
		.uart_rx_empty (uart_rx_empty),
		.uart_rx_rd_en (uart_rx_rd_en)
	);

	// the last three-byte load is the signature, qualified by done
	assign device_id = rx_bytes;

endmodule

`default_nettype wire

//--- verif/updi_target_model.sv
// behavioral UPDI target with TX frame parser, RX response queue and random TX back-pressure
`timescale 1ns/1ps
`default_nettype none
`include "updi_cfg.svh"

module updi_target_model (
	input  logic                   clk,
	input  logic                   rst,
	input  updi_pkg::updi_byte_t   uart_tx_data,
	input  logic                   uart_tx_wr_en,
	output logic                   uart_tx_full,
	output updi_pkg::updi_byte_t   uart_rx_data,
	output logic                   uart_rx_empty,
	input  logic                   uart_rx_rd_en,
	input  logic                   break_start,
	output logic                   break_done,
	input  updi_pkg::updi_dev_id_t dev_id,
	input  updi_pkg::updi_byte_t   statusa,
	input  updi_pkg::updi_byte_t   key_status,
	input  int                     not_ready_polls,
	input  logic                   rand_full,
	output logic                   tx_seen,
	output updi_pkg::updi_byte_t   tx_byte
);

	updi_pkg::updi_byte_t rx_q[$];
	updi_pkg::updi_byte_t op;
	int                   pos;
	int                   need;
	int                   polls;
	int                   rpt;
	int                   break_cnt;
	logic [15:0]          ptr;
	logic [31:0]          rnd;
	int                   seed;

	initial begin
		seed          = 32'hd113_b1a4;
		uart_tx_full  = 1'b0;
		uart_rx_data  = 8'h00;
		uart_rx_empty = 1'b1;
		break_done    = 1'b0;
		tx_seen       = 1'b0;
		tx_byte       = 8'h00;
		break_cnt     = 0;
	end

	// answer to an LDCS
	// SYS_STATUS has every bit but bit 3 set for the first K reads and then reads ready
	function automatic updi_pkg::updi_byte_t cs_value(input logic [3:0] addr);
		case (addr)
			`UPDI_CS_STATUSA:    return statusa;
			`UPDI_CS_KEY_STATUS: return key_status;
			`UPDI_CS_SYS_STATUS: return (polls < not_ready_polls) ? 8'hF7 : 8'h08;
			default:             return 8'h00;
		endcase
	endfunction

	task automatic parse_byte(input updi_pkg::updi_byte_t b);
		int idx;
		if (pos == 0) begin
			// bytes outside a frame are ignored until the next sync
			if (b == `UPDI_SYNC) begin
				pos = 1;
			end
		end else if (pos == 1) begin
			op   = b;
			pos  = 2;
			need = 0;
			if (b[7:4] == 4'h8) begin
				rx_q.push_back(cs_value(b[3:0]));
				if (b[3:0] == `UPDI_CS_SYS_STATUS) begin
					polls++;
				end
			end else if (b[7:4] == 4'hC || b == `UPDI_OP_REPEAT) begin
				need = 1;
			end else if (b == `UPDI_OP_KEY) begin
				need = 8;
			end else if (b == `UPDI_OP_ST_PTR) begin
				need = 2;
			end else if (b == `UPDI_OP_LD_INC) begin
				// repeat count plus one loads with the pointer advancing after each
				for (int i = 0; i <= rpt; i++) begin
					idx = int'(ptr) - int'(`UPDI_SIG_BASE);
					if (idx >= 0 && idx < `UPDI_ID_BYTES) begin
						rx_q.push_back(dev_id[idx]);
					end else begin
						rx_q.push_back(8'hFF);
					end
					ptr++;
				end
				rpt = 0;
			end
			if (need == 0) begin
				pos = 0;
			end
		end else begin
			if (op == `UPDI_OP_ST_PTR && need == 2) begin
				ptr[7:0] = b;
			end else if (op == `UPDI_OP_ST_PTR) begin
				ptr[15:8] = b;
			end else if (op == `UPDI_OP_REPEAT) begin
				rpt = b;
			end
			need--;
			if (need == 0) begin
				pos = 0;
			end
		end
	endtask

	// pops and TX bytes are taken on the rising edge
	always @(posedge clk) begin
		tx_seen <= 1'b0;
		if (rst) begin
			rx_q.delete();
			pos   = 0;
			need  = 0;
			polls = 0;
			rpt   = 0;
			ptr   = 16'h0000;
		end else begin
			if (uart_rx_rd_en && rx_q.size() != 0) begin
				void'(rx_q.pop_front());
			end
			if (break_start) begin
				polls = 0;
				pos   = 0;
			end
			if (uart_tx_wr_en && !uart_tx_full) begin
				tx_seen <= 1'b1;
				tx_byte <= uart_tx_data;
				parse_byte(uart_tx_data);
			end
		end
	end

	// everything the DUT samples changes on the falling edge
	always @(negedge clk) begin
		rnd = $random(seed);
		break_done <= 1'b0;
		if (rst) begin
			uart_tx_full <= 1'b0;
			break_cnt = 0;
		end else begin
			uart_tx_full <= rand_full & rnd[0];
			if (break_cnt != 0) begin
				break_cnt--;
				if (break_cnt == 0) begin
					break_done <= 1'b1;
				end
			end
			if (break_start) begin
				break_cnt = 6;
			end
		end
		uart_rx_empty <= rx_q.size() == 0;
		uart_rx_data  <= (rx_q.size() != 0) ? rx_q[0] : 8'h00;
	end

endmodule

`default_nettype wire

//--- verif/updi_programmer_asserts.sv
// concurrent checks on reset, TX flow control, break strobe and result strobes of the top level
`timescale 1ns/1ps
`default_nettype none

module updi_programmer_asserts (
	input logic clk,
	input logic rst,
	input logic busy,
	input logic done,
	input logic error,
	input logic uart_tx_wr_en,
	input logic uart_tx_full,
	input logic break_start
);

	// number of failed assertions so far
	int fail_count = 0;

	a_idle_after_reset: assert property (@(posedge clk) rst |=> !busy)
		else begin
			fail_count++;
			$error("busy is high in the cycle after reset");
		end

	a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
		!(uart_tx_wr_en && uart_tx_full))
		else begin
			fail_count++;
			$error("TX write while the FIFO is full");
		end

	a_break_one_cycle: assert property (@(posedge clk) disable iff (rst)
		break_start |=> !break_start)
		else begin
			fail_count++;
			$error("break_start high for two cycles");
		end

	a_done_or_error: assert property (@(posedge clk) disable iff (rst) !(done && error))
		else begin
			fail_count++;
			$error("done and error high together");
		end

endmodule

bind updi_programmer updi_programmer_asserts updi_programmer_asserts_i (
	.clk           (clk),
	.rst           (rst),
	.busy          (busy),
	.done          (done),
	.error         (error),
	.uart_tx_wr_en (uart_tx_wr_en),
	.uart_tx_full  (uart_tx_full),
	.break_start   (break_start)
);

`default_nettype wire

//--- verif/tb_updi_programmer.sv
// testbench for the UPDI programmer with reference frames, compare process, watchdog and scenarios
`timescale 1ns/1ps
`default_nettype none
`include "updi_cfg.svh"

module tb_updi_programmer;

	localparam int FAIL_NONE   = 0;
	localparam int FAIL_STATUS = 1;
	localparam int FAIL_KEY    = 2;
	localparam int FAIL_POLL   = 3;
	localparam int SCENARIOS   = 6;
	localparam int WATCHDOG_CYCLES =
		SCENARIOS * (`UPDI_MAX_POLLS + 2) * (`UPDI_DELAY_CLKS + 200);
	localparam logic [15:0] SIG_BASE = `UPDI_SIG_BASE;

	logic                   clk;
	logic                   rst;
	logic                   start;
	logic                   busy;
	logic                   done;
	logic                   error;
	updi_pkg::updi_err_e    error_code;
	updi_pkg::updi_dev_id_t device_id;
	updi_pkg::updi_byte_t   uart_tx_data;
	logic                   uart_tx_wr_en;
	logic                   uart_tx_full;
	updi_pkg::updi_byte_t   uart_rx_data;
	logic                   uart_rx_empty;
	logic                   uart_rx_rd_en;
	logic                   break_start;
	logic                   break_done;

	// target configuration and its TX log strobe
	updi_pkg::updi_dev_id_t dev_id;
	updi_pkg::updi_byte_t   statusa;
	updi_pkg::updi_byte_t   key_status;
	int                     not_ready_polls;
	logic                   rand_full;
	logic                   tx_seen;
	updi_pkg::updi_byte_t   tx_byte;

	updi_pkg::updi_byte_t   exp_q[$];
	int                     exp_idx;

	updi_programmer updi_programmer_i (
		.clk           (clk),
		.rst           (rst),
		.start         (start),
		.busy          (busy),
		.done          (done),
		.error         (error),
		.error_code    (error_code),
		.device_id     (device_id),
		.uart_tx_data  (uart_tx_data),
		.uart_tx_wr_en (uart_tx_wr_en),
		.uart_tx_full  (uart_tx_full),
		.uart_rx_data  (uart_rx_data),
		.uart_rx_empty (uart_rx_empty),
		.uart_rx_rd_en (uart_rx_rd_en),
		.break_start   (break_start),
		.break_done    (break_done)
	);

	updi_target_model target_i (
		.clk             (clk),
		.rst             (rst),
		.uart_tx_data    (uart_tx_data),
		.uart_tx_wr_en   (uart_tx_wr_en),
		.uart_tx_full    (uart_tx_full),
		.uart_rx_data    (uart_rx_data),
		.uart_rx_empty   (uart_rx_empty),
		.uart_rx_rd_en   (uart_rx_rd_en),
		.break_start     (break_start),
		.break_done      (break_done),
		.dev_id          (dev_id),
		.statusa         (statusa),
		.key_status      (key_status),
		.not_ready_polls (not_ready_polls),
		.rand_full       (rand_full),
		.tx_seen         (tx_seen),
		.tx_byte         (tx_byte)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abort_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic fail_with(input string why);
		$display("%s", why);
		abort_run();
	endtask

	task automatic check_byte(input string name, input updi_pkg::updi_byte_t got,
			input updi_pkg::updi_byte_t want);
		if (got !== want) begin
			$display("Error at %0t: %s is 8'h%02h, expected 8'h%02h", $time, name, got, want);
			abort_run();
		end
	endtask

	task automatic check_id(input string name, input updi_pkg::updi_dev_id_t got,
			input updi_pkg::updi_dev_id_t want);
		if (got !== want) begin
			$display("Error at %0t: %s is 24'h%06h, expected 24'h%06h", $time, name, got, want);
			abort_run();
		end
	endtask

	task automatic check_err(input string name, input updi_pkg::updi_err_e got,
			input updi_pkg::updi_err_e want);
		if (got !== want) begin
			$display("Error at %0t: %s is %s, expected %s", $time, name, got.name(),
				want.name());
			abort_run();
		end
	endtask

	// sync plus opcode
	function automatic void push_head(input updi_pkg::updi_byte_t op);
		exp_q.push_back(`UPDI_SYNC);
		exp_q.push_back(op);
	endfunction

	// expected TX bytes for K not-ready polls, cut short at the failing check
	function automatic void build_expected(input int k, input int fail_at);
		int n_polls;
		exp_q.delete();
		push_head(`UPDI_OP_LDCS + `UPDI_CS_STATUSA);
		if (fail_at == FAIL_STATUS) begin
			return;
		end
		push_head(`UPDI_OP_KEY);
		exp_q.push_back(`UPDI_KEY_NVMPROG_B0);
		exp_q.push_back(`UPDI_KEY_NVMPROG_B1);
		exp_q.push_back(`UPDI_KEY_NVMPROG_B2);
		exp_q.push_back(`UPDI_KEY_NVMPROG_B3);
		exp_q.push_back(`UPDI_KEY_NVMPROG_B4);
		exp_q.push_back(`UPDI_KEY_NVMPROG_B5);
		exp_q.push_back(`UPDI_KEY_NVMPROG_B6);
		exp_q.push_back(`UPDI_KEY_NVMPROG_B7);
		push_head(`UPDI_OP_LDCS + `UPDI_CS_KEY_STATUS);
		if (fail_at == FAIL_KEY) begin
			return;
		end
		push_head(`UPDI_OP_STCS + `UPDI_CS_RESET_REQ);
		exp_q.push_back(`UPDI_RESET_SIG);
		push_head(`UPDI_OP_STCS + `UPDI_CS_RESET_REQ);
		exp_q.push_back(8'h00);
		// K reads see not ready, one more sees ready, unless the limit comes first
		n_polls = (fail_at == FAIL_POLL) ? `UPDI_MAX_POLLS : k + 1;
		for (int i = 0; i < n_polls; i++) begin
			push_head(`UPDI_OP_LDCS + `UPDI_CS_SYS_STATUS);
		end
		if (fail_at == FAIL_POLL) begin
			return;
		end
		push_head(`UPDI_OP_ST_PTR);
		exp_q.push_back(SIG_BASE[7:0]);
		exp_q.push_back(SIG_BASE[15:8]);
		push_head(`UPDI_OP_REPEAT);
		exp_q.push_back(8'(`UPDI_ID_BYTES - 1));
		push_head(`UPDI_OP_LD_INC);
	endfunction

	// each byte the target logged is compared in order
	initial begin
		exp_idx = 0;
		forever begin
			@(posedge clk);
			if (tx_seen) begin
				if (exp_idx >= exp_q.size()) begin
					fail_with($sformatf("unexpected extra TX byte 8'h%02h at %0t", tx_byte, $time));
				end else begin
					check_byte($sformatf("uart_tx_data[%0d]", exp_idx), tx_byte, exp_q[exp_idx]);
					exp_idx++;
				end
			end
		end
	end

	task automatic run_scenario(input string label, input int k, input int fail_at,
			input logic random_full, input updi_pkg::updi_byte_t status_a,
			input updi_pkg::updi_byte_t key_stat);
		updi_pkg::updi_err_e want_err;
		$display("scenario: %s", label);
		case (fail_at)
			FAIL_STATUS: want_err = updi_pkg::ERR_NO_STATUS;
			FAIL_KEY:    want_err = updi_pkg::ERR_KEY_LOCKED;
			FAIL_POLL:   want_err = updi_pkg::ERR_POLL_TIMEOUT;
			default:     want_err = updi_pkg::ERR_NONE;
		endcase
		@(negedge clk);
		not_ready_polls = k;
		rand_full       = random_full;
		statusa         = status_a;
		key_status      = key_stat;
		build_expected(k, fail_at);
		exp_idx = 0;
		start   = 1'b1;
		@(negedge clk);
		start = 1'b0;
		@(posedge clk);
		while (!done && !error) begin
			@(posedge clk);
		end
		if (fail_at == FAIL_NONE) begin
			if (error) begin
				fail_with($sformatf("%s ended with an error strobe instead of done", label));
			end
			check_id("device_id", device_id, dev_id);
		end else if (done) begin
			fail_with($sformatf("%s ended with done instead of an error strobe", label));
		end
		check_err("error_code", error_code, want_err);
		@(posedge clk);
		if (busy) begin
			fail_with($sformatf("%s left busy high after the closing strobe", label));
		end
		// let any late TX byte reach the compare process
		repeat (20) @(posedge clk);
		if (exp_idx != exp_q.size()) begin
			fail_with($sformatf("%s sent %0d TX bytes, expected %0d", label, exp_idx,
				exp_q.size()));
		end
	endtask

	initial begin
		rst             = 1'b1;
		start           = 1'b0;
		rand_full       = 1'b0;
		not_ready_polls = 2;
		statusa         = 8'h30;
		key_status      = 8'h10;
		dev_id[0]       = 8'h1E;
		dev_id[1]       = 8'h95;
		dev_id[2]       = 8'h0F;
		repeat (4) @(negedge clk);
		rst = 1'b0;

		run_scenario("normal run", 2, FAIL_NONE, 1'b0, 8'h30, 8'h10);
		run_scenario("TX back-pressure", 2, FAIL_NONE, 1'b1, 8'h30, 8'h10);
		run_scenario("zero STATUSA", 2, FAIL_STATUS, 1'b0, 8'h00, 8'h10);
		// every key status bit set except the NVMPROG one
		run_scenario("key refused", 2, FAIL_KEY, 1'b0, 8'h30, 8'hEF);
		run_scenario("poll limit", `UPDI_MAX_POLLS + 2, FAIL_POLL, 1'b0, 8'h30, 8'h10);
		run_scenario("restart after error", 2, FAIL_NONE, 1'b0, 8'h30, 8'h10);

		if (updi_programmer_i.updi_programmer_asserts_i.fail_count != 0) begin
			fail_with("a bound assertion failed during the run");
		end else begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		fail_with($sformatf("run timed out after %0d clock cycles", WATCHDOG_CYCLES));
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+common
common/updi_pkg.sv
rtl/updi_frame_tx.sv
rtl/updi_rx_collect.sv
updi_prog_ctrl/updi_prog_ctrl.sv
rtl/updi_programmer.sv
verif/updi_target_model.sv
verif/updi_programmer_asserts.sv
verif/tb_updi_programmer.sv

//--- Bender.yml
package:
  name: updi_programmer

export_include_dirs:
  - common

sources:
  - files:
      - common/updi_pkg.sv
      - rtl/updi_frame_tx.sv
      - rtl/updi_rx_collect.sv
      - updi_prog_ctrl/updi_prog_ctrl.sv
      - rtl/updi_programmer.sv
  - target: test
    files:
      - verif/updi_target_model.sv
      - verif/updi_programmer_asserts.sv
      - verif/tb_updi_programmer.sv
